/* logic/bus_setup_pkg.sv */
`default_nettype none

package bus_setup_pkg;

    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 3;
    localparam int DATA_W      = 16;

    localparam int SLAVE_DEPTHS [NUM_SLAVES] = '{4096, 4096, 2048};

    // deepest slave sets the master address width
    function automatic int max_depth();
        int deepest;
        deepest = 0;
        foreach (SLAVE_DEPTHS[i]) begin
            if (SLAVE_DEPTHS[i] > deepest) begin
                deepest = SLAVE_DEPTHS[i];
            end
        end
        return deepest;
    endfunction

    localparam int ADDR_W             = $clog2(max_depth());
    localparam int BANK_DEPTH         = 16;  // externally written words per master
    localparam int CONFIG_SLOT_CYCLES = 2;   // cycles each config word is held

    typedef logic [DATA_W-1:0]               data_t;
    typedef logic [ADDR_W-1:0]               addr_t;
    typedef logic [$clog2(NUM_SLAVES+1)-1:0] slave_id_t;   // 0 means no slave
    typedef logic [$clog2(BANK_DEPTH)-1:0]   bank_addr_t;

    typedef enum logic [3:0] {
        sel_slave,
        sel_rw,
        sel_ext,
        ext_write_m0,
        ext_write_m01,
        ext_write_m1,
        first_addr_m0,
        first_addr_m1,
        count_m0,
        count_m1,
        configuring,
        com_ready,
        communicating,
        com_done
    } phase_t;

    typedef struct packed {
        logic      start;
        logic      burst;       // more than one word was written
        logic      rd_wr;       // 1 = write
        logic      ext_write;
        slave_id_t slave_id;
        addr_t     address;
        addr_t     last_addr;
        data_t     data;
    } master_cmd_t;

endpackage

`default_nettype wire

/* logic/setup_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module setup_fsm (
    input  wire logic                                  clk,
    input  wire logic                                  rstN,
    input  wire logic                                  step,
    input  wire logic [3:0]                            sw_slaves,
    input  wire logic [1:0]                            sw_ext,
    input  wire logic                                  config_done,
    input  wire logic [bus_setup_pkg::NUM_MASTERS-1:0] com_done,
    output bus_setup_pkg::phase_t                      phase,
    output logic                                       com_start
);
    import bus_setup_pkg::*;

    phase_t step_target;  // where a step strobe would take us
    phase_t phase_next;

    // one cycle strobe when leaving com_ready; the sequencer registers it
    assign com_start = (phase == com_ready) && step;

    // the com_done port hides the phase literal so it is named with its package
    always_comb begin
        step_target = phase;
        case (phase)
            sel_slave:     step_target = (sw_slaves == '0) ? bus_setup_pkg::com_done : sel_rw;
            sel_rw:        step_target = sel_ext;
            sel_ext: begin
                case (sw_ext)
                    2'd0: step_target = first_addr_m0;
                    2'd1: step_target = ext_write_m0;
                    2'd2: step_target = ext_write_m1;
                    2'd3: step_target = ext_write_m01;
                endcase
            end
            ext_write_m01: step_target = ext_write_m1;   // master 0 words first
            ext_write_m0,
            ext_write_m1:  step_target = first_addr_m0;
            first_addr_m0: step_target = first_addr_m1;
            first_addr_m1: step_target = count_m0;
            count_m0:      step_target = count_m1;
            count_m1:      step_target = configuring;
            com_ready:     step_target = communicating;
            default:       step_target = phase;           // step ignored here
        endcase
    end

    always_comb begin
        phase_next = phase;
        if (phase == configuring) begin
            if (config_done) begin
                phase_next = com_ready;
            end
        end else if (phase == communicating) begin
            if (&com_done) begin
                phase_next = bus_setup_pkg::com_done;
            end
        end else if (step) begin
            phase_next = step_target;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= sel_slave;
        end else begin
            phase <= phase_next;  // com_done has no way out but reset
        end
    end

endmodule

`default_nettype wire

/* logic/master_setup_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module master_setup_regs (
    input  wire logic                                                 clk,
    input  wire logic                                                 rstN,
    input  wire bus_setup_pkg::phase_t                                phase,
    input  wire logic [17:0]                                          sw,
    input  wire logic                                                 next_addr,
    input  wire bus_setup_pkg::data_t [bus_setup_pkg::NUM_MASTERS-1:0] master_data,
    output bus_setup_pkg::slave_id_t  [bus_setup_pkg::NUM_MASTERS-1:0] slave_id,
    output logic                      [bus_setup_pkg::NUM_MASTERS-1:0] rd_wr,
    output logic                      [bus_setup_pkg::NUM_MASTERS-1:0] ext_write,
    output bus_setup_pkg::addr_t      [bus_setup_pkg::NUM_MASTERS-1:0] first_addr,
    output bus_setup_pkg::addr_t      [bus_setup_pkg::NUM_MASTERS-1:0] last_addr,
    output bus_setup_pkg::addr_t      [bus_setup_pkg::NUM_MASTERS-1:0] done_addr,
    output bus_setup_pkg::data_t      [bus_setup_pkg::NUM_MASTERS-1:0] readback
);
    import bus_setup_pkg::*;

    // depth of the chosen slave with the full range when none is chosen
    function automatic logic [ADDR_W:0] depth_of(input slave_id_t id);
        logic [ADDR_W:0] depth;
        depth = (ADDR_W+1)'(max_depth());
        if (id != '0) begin
            depth = (ADDR_W+1)'(SLAVE_DEPTHS[id - 1'b1]);
        end
        return depth;
    endfunction

    function automatic addr_t clamp_last(input addr_t first, input addr_t count,
                                         input slave_id_t id);
        logic [ADDR_W:0] sum;
        logic [ADDR_W:0] depth;
        addr_t           last;
        sum   = {1'b0, first} + {1'b0, count};  // one extra bit for the carry
        depth = depth_of(id);
        last  = sum[ADDR_W-1:0];
        if (sum >= depth) begin
            last = addr_t'(depth - 1'b1);   // stop at the slave's top word
        end
        return last;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slave_id   <= '0;
            rd_wr      <= '0;
            ext_write  <= '0;
            first_addr <= '0;
            last_addr  <= '0;
            done_addr  <= '0;
            readback   <= '0;
        end else begin
            case (phase)
                sel_slave: begin
                    slave_id[0] <= sw[1:0];
                    slave_id[1] <= sw[3:2];
                end
                sel_rw:        rd_wr         <= sw[NUM_MASTERS-1:0];
                sel_ext:       ext_write     <= sw[NUM_MASTERS-1:0];
                first_addr_m0: first_addr[0] <= sw[ADDR_W-1:0];
                first_addr_m1: first_addr[1] <= sw[ADDR_W-1:0];
                count_m0: last_addr[0] <= clamp_last(first_addr[0], sw[ADDR_W-1:0], slave_id[0]);
                count_m1: last_addr[1] <= clamp_last(first_addr[1], sw[ADDR_W-1:0], slave_id[1]);
                com_done: begin
                    readback <= master_data;  // both masters read the same address
                    if (next_addr) begin
                        done_addr <= {NUM_MASTERS{sw[ADDR_W-1:0]}};
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/write_data_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module write_data_bank (
    input  wire logic                                      clk,
    input  wire logic                                      rstN,
    input  wire bus_setup_pkg::phase_t                     phase,
    input  wire bus_setup_pkg::data_t                      sw_data,
    input  wire logic                                      next_addr,
    input  wire logic                                      step,
    input  wire logic                                      rd_master,
    input  wire bus_setup_pkg::bank_addr_t                 rd_index,
    output bus_setup_pkg::data_t                           rd_word,
    output bus_setup_pkg::bank_addr_t [bus_setup_pkg::NUM_MASTERS-1:0] word_count,
    output logic                      [bus_setup_pkg::NUM_MASTERS-1:0] burst
);
    import bus_setup_pkg::*;

    data_t      bank [NUM_MASTERS][BANK_DEPTH];
    bank_addr_t wr_ptr;      // shared by both masters and cleared on step
    logic       wr_active;
    logic       wr_master;

    always_comb begin
        wr_active = 1'b1;
        wr_master = 1'b0;
        case (phase)
            ext_write_m0,
            ext_write_m01: wr_master = 1'b0;
            ext_write_m1:  wr_master = 1'b1;
            default:       wr_active = 1'b0;
        endcase
    end

    // switch word is stored every cycle so the last value before a strobe stays
    always_ff @(posedge clk) begin
        if (wr_active) begin
            bank[wr_master][wr_ptr] <= sw_data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_ptr     <= '0;
            word_count <= '0;
            burst      <= '0;
        end else if (wr_active) begin
            if (step) begin
                wr_ptr <= '0;  // next master starts at location zero
            end else if (next_addr) begin
                wr_ptr                <= wr_ptr + 1'b1;
                burst[wr_master]      <= 1'b1;
                word_count[wr_master] <= word_count[wr_master] + 1'b1;
            end
        end
    end

    assign rd_word = bank[rd_master][rd_index];  // same-cycle read for the sequencer

endmodule

`default_nettype wire

/* logic/config_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module config_sequencer (
    input  wire logic                                                  clk,
    input  wire logic                                                  rstN,
    input  wire bus_setup_pkg::phase_t                                 phase,
    input  wire logic                       [bus_setup_pkg::NUM_MASTERS-1:0] ext_write,
    input  wire bus_setup_pkg::bank_addr_t  [bus_setup_pkg::NUM_MASTERS-1:0] word_count,
    input  wire bus_setup_pkg::data_t                                  rd_word,
    input  wire bus_setup_pkg::addr_t       [bus_setup_pkg::NUM_MASTERS-1:0] first_addr,
    input  wire bus_setup_pkg::addr_t       [bus_setup_pkg::NUM_MASTERS-1:0] done_addr,
    input  wire logic                                                  com_start,
    output logic                                                       rd_master,
    output bus_setup_pkg::bank_addr_t                                  rd_index,
    output logic                            [bus_setup_pkg::NUM_MASTERS-1:0] start,
    output bus_setup_pkg::data_t            [bus_setup_pkg::NUM_MASTERS-1:0] data,
    output bus_setup_pkg::addr_t            [bus_setup_pkg::NUM_MASTERS-1:0] address,
    output logic                                                       config_done
);
    import bus_setup_pkg::*;

    typedef enum logic [1:0] {start_slot, middle_slot, last_slot, done} sub_state_t;

    sub_state_t                            state;
    logic [$clog2(CONFIG_SLOT_CYCLES)-1:0] slot_cycle;
    bank_addr_t                            word_idx;
    logic                                  master;     // master being configured
    bank_addr_t                            last_idx;
    logic                                  slot_end;
    logic                                  active;
    logic                                  word_valid;

    assign active   = (phase == configuring) && (state != done);
    assign slot_end = (slot_cycle == CONFIG_SLOT_CYCLES - 1);

    // last slot index is the final written word or else the fixed second slot
    assign last_idx = (ext_write[master] && word_count[master] != '0) ?
                      word_count[master] : bank_addr_t'(1);
    assign word_valid = ext_write[master] && (word_idx <= word_count[master]);

    assign rd_master   = master;
    assign rd_index    = word_idx;
    assign config_done = (state == done);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= start_slot;
            slot_cycle <= '0;
            word_idx   <= '0;
            master     <= 1'b0;
        end else if (phase != configuring) begin
            state      <= start_slot;  // rearmed for the next configuration
            slot_cycle <= '0;
            word_idx   <= '0;
            master     <= 1'b0;
        end else if (active) begin
            slot_cycle <= slot_end ? '0 : slot_cycle + 1'b1;
            if (slot_end) begin
                if (state == last_slot) begin
                    word_idx <= '0;
                    if (master == 1'(NUM_MASTERS - 1)) begin
                        state <= done;
                    end else begin
                        master <= master + 1'b1;
                        state  <= start_slot;
                    end
                end else begin
                    word_idx <= word_idx + 1'b1;
                    state    <= (word_idx + 1'b1 == last_idx) ? last_slot : middle_slot;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            start   <= '0;
            data    <= '0;
            address <= '0;
        end else begin
            start <= {NUM_MASTERS{com_start}};   // common start pulse for both
            if (active) begin
                data[master] <= word_valid ? rd_word : '0;  // unwritten slots send zero
                if (slot_cycle == '0 && state != middle_slot) begin
                    start[master] <= 1'b1;
                end
                if (state == start_slot) begin
                    address[master] <= first_addr[master];
                end
            end
            if (phase == com_done) begin
                address <= done_addr;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/bus_setup_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_setup_top (
    input  wire logic                                          clk,
    input  wire logic                                          rstN,
    input  wire logic [17:0]                                   sw,
    input  wire logic                                          step,
    input  wire logic                                          next_addr,
    input  wire logic [bus_setup_pkg::NUM_MASTERS-1:0]         com_done,
    input  wire bus_setup_pkg::data_t [bus_setup_pkg::NUM_MASTERS-1:0] master_data,
    output bus_setup_pkg::master_cmd_t [bus_setup_pkg::NUM_MASTERS-1:0] cmd,
    output bus_setup_pkg::phase_t                              phase,
    output bus_setup_pkg::data_t [bus_setup_pkg::NUM_MASTERS-1:0] readback
);
    import bus_setup_pkg::*;

    logic                          config_done;
    logic                          com_start;
    slave_id_t  [NUM_MASTERS-1:0]  slave_id;
    logic       [NUM_MASTERS-1:0]  rd_wr;
    logic       [NUM_MASTERS-1:0]  ext_write;
    addr_t      [NUM_MASTERS-1:0]  first_addr;
    addr_t      [NUM_MASTERS-1:0]  last_addr;
    addr_t      [NUM_MASTERS-1:0]  done_addr;
    bank_addr_t [NUM_MASTERS-1:0]  word_count;
    logic       [NUM_MASTERS-1:0]  burst;
    logic                          rd_master;
    bank_addr_t                    rd_index;
    data_t                         rd_word;
    logic       [NUM_MASTERS-1:0]  start;
    data_t      [NUM_MASTERS-1:0]  data;
    addr_t      [NUM_MASTERS-1:0]  address;

    setup_fsm u_fsm (
        .clk, .rstN, .step,
        .sw_slaves(sw[3:0]), .sw_ext(sw[1:0]),
        .config_done, .com_done, .phase, .com_start
    );

    master_setup_regs u_regs (
        .clk, .rstN, .phase, .sw, .next_addr, .master_data,
        .slave_id, .rd_wr, .ext_write, .first_addr, .last_addr, .done_addr, .readback
    );

    write_data_bank u_bank (
        .clk, .rstN, .phase, .sw_data(sw[DATA_W-1:0]), .next_addr, .step,
        .rd_master, .rd_index, .rd_word, .word_count, .burst
    );

    config_sequencer u_seq (
        .clk, .rstN, .phase, .ext_write, .word_count, .rd_word, .first_addr, .done_addr,
        .com_start, .rd_master, .rd_index, .start, .data, .address, .config_done
    );

    // command fields come from the setup registers and the sequencer
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            cmd[i].start     = start[i];
            cmd[i].burst     = burst[i];
            cmd[i].rd_wr     = rd_wr[i];
            cmd[i].ext_write = ext_write[i];
            cmd[i].slave_id  = slave_id[i];
            cmd[i].address   = address[i];
            cmd[i].last_addr = last_addr[i];
            cmd[i].data      = data[i];
        end
    end

endmodule

`default_nettype wire

/* test/bus_setup_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_setup_assertions (
    input wire logic                                               clk,
    input wire logic                                               rstN,
    input wire logic                                               step,
    input wire logic [bus_setup_pkg::NUM_MASTERS-1:0]              done_bits,
    input wire bus_setup_pkg::phase_t                              phase,
    input wire bus_setup_pkg::master_cmd_t [bus_setup_pkg::NUM_MASTERS-1:0] cmd
);
    import bus_setup_pkg::*;

    int unsigned fail_count = 0;  // number of failed assertions

    // session always opens in the slave selection phase
    a_reset_phase: assert property (@(posedge clk) disable iff (!rstN)
        $rose(rstN) |-> phase == sel_slave)
        else begin
            fail_count++;
            $error("phase is not sel_slave after reset");
        end

    // a start comes only from configuration or from the step that leaves com_ready
    a_start_source: assert property (@(posedge clk) disable iff (!rstN)
        (cmd[0].start || cmd[1].start) |->
            ($past(phase) == configuring) || ($past(phase) == com_ready && $past(step)))
        else begin
            fail_count++;
            $error("start raised outside configuration or common start");
        end

    a_common_start: assert property (@(posedge clk) disable iff (!rstN)
        (phase == com_ready && step) |=>
            (cmd[0].start && cmd[1].start) ##1 !(cmd[0].start || cmd[1].start))
        else begin
            fail_count++;
            $error("common start is not a single cycle on both masters");
        end

    a_done_waits: assert property (@(posedge clk) disable iff (!rstN)
        (phase == communicating && !(&done_bits)) |=> phase != com_done)
        else begin
            fail_count++;
            $error("com_done reached before every master was done");
        end

    a_done_follows: assert property (@(posedge clk) disable iff (!rstN)
        (phase == communicating && (&done_bits)) |=> phase == com_done)
        else begin
            fail_count++;
            $error("com_done not entered after every master was done");
        end

    a_done_holds: assert property (@(posedge clk) disable iff (!rstN)
        phase == com_done |=> phase == com_done)
        else begin
            fail_count++;
            $error("phase left com_done without reset");
        end

endmodule

`default_nettype wire

/* test/bus_setup_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_setup_tb;
    import bus_setup_pkg::*;

    localparam int CLK_PERIOD     = 20;
    // worst case: two resets, strobes, configuration, slowest master and readback
    localparam int SESSION_CYCLES = 2 * 5 + 13 + 11 + 12 + 4;

    logic                          clk;
    logic                          rstN;
    logic [17:0]                   sw;
    logic                          step;
    logic                          next_addr;
    logic [NUM_MASTERS-1:0]        done_bits = '0;
    data_t [NUM_MASTERS-1:0]       master_data = '0;
    master_cmd_t [NUM_MASTERS-1:0] cmd;
    phase_t                        phase;
    data_t [NUM_MASTERS-1:0]       readback;

    int unsigned done_delay [NUM_MASTERS] = '{3, 3};
    int unsigned wait_left [NUM_MASTERS] = '{0, 0};

    bus_setup_top dut (
        .clk, .rstN, .sw, .step, .next_addr, .com_done(done_bits), .master_data,
        .cmd, .phase, .readback
    );

    bind bus_setup_top bus_setup_assertions chk (
        .clk(clk), .rstN(rstN), .step(step), .done_bits(com_done), .phase(phase), .cmd(cmd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // word a master returns for an address
    function automatic data_t model_word(input int m, input addr_t a);
        return data_t'({a, 4'h0}) ^ ((m == 0) ? 16'h1e87 : 16'hc35a);
    endfunction

    // master models raise done a few cycles after the common start
    always @(posedge clk) begin
        #2;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            master_data[m] = model_word(m, cmd[m].address);
            if (!rstN) begin
                done_bits[m] = 1'b0;
                wait_left[m] = 0;
            end else if (cmd[m].start && phase == communicating) begin
                wait_left[m] = done_delay[m];
            end else if (wait_left[m] != 0) begin
                wait_left[m]--;
                if (wait_left[m] == 0) done_bits[m] = 1'b1;
            end
        end
    end

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #2 rstN = 1'b1;
    endtask

    task automatic pulse_step();
        step = 1'b1;
        next_cycle();
        step = 1'b0;
    endtask

    task automatic pulse_next_addr();
        next_addr = 1'b1;
        next_cycle();
        next_addr = 1'b0;
    endtask

    always @(posedge clk) begin
        if (dut.chk.fail_count != 0) begin
            $display("a bound timing assertion failed");
            stop_run();
        end
    end

    initial begin
        #(20 * SESSION_CYCLES * CLK_PERIOD);
        $display("watchdog timeout, the session did not finish");
        stop_run();
    end

    initial begin
        data_t       words [3];
        data_t       seen [$];
        int unsigned starts [NUM_MASTERS];
        addr_t       first0;
        addr_t       count0;
        addr_t       new_addr;
        int          cycles;

        void'($urandom(32'h6ad3_35b6));
        sw        = '0;
        step      = 1'b0;
        next_addr = 1'b0;
        apply_reset();
        check_value("phase after reset", sel_slave, phase);
        check_value("start after reset", 0, {cmd[1].start, cmd[0].start});
        pulse_step();                           // no slave chosen
        check_value("no slave skips to com_done", com_done, phase);

        apply_reset();
        sw = 18'h0000d;                         // m0 on slave 1, m1 on slave 3
        pulse_step();
        sw = 18'h00001;                         // m0 writes
        pulse_step();
        sw = 18'h00001;                         // external words for m0 only
        pulse_step();
        check_value("ext write phase", ext_write_m0, phase);
        foreach (words[i]) words[i] = data_t'($urandom);
        for (int i = 0; i < 3; i++) begin
            sw = {2'b00, words[i]};
            if (i < 2) pulse_next_addr();
            else pulse_step();
        end
        first0 = addr_t'($urandom_range(999));
        count0 = addr_t'($urandom_range(999));
        sw = {6'd0, first0};
        pulse_step();
        sw = 18'd2000;
        pulse_step();
        sw = {6'd0, count0};
        pulse_step();
        sw = 18'd100;
        pulse_step();
        check_value("phase after counts", configuring, phase);
        check_value("last_addr m0", first0 + count0, cmd[0].last_addr);
        check_value("last_addr m1 clamped", 2047, cmd[1].last_addr);
        check_value("slave_id m0", 1, cmd[0].slave_id);
        check_value("slave_id m1", 3, cmd[1].slave_id);
        check_value("rd_wr", 2'b01, {cmd[1].rd_wr, cmd[0].rd_wr});
        check_value("ext_write", 2'b01, {cmd[1].ext_write, cmd[0].ext_write});
        check_value("burst m0", 1, cmd[0].burst);
        check_value("burst m1", 0, cmd[1].burst);

        starts = '{0, 0};
        cycles = 0;
        while (phase == configuring) begin
            for (int m = 0; m < NUM_MASTERS; m++) if (cmd[m].start) starts[m]++;
            if ((cmd[0].start && seen.size() == 0) || (seen.size() inside {[1:5]}))
                seen.push_back(cmd[0].data);
            cycles++;
            if (cycles > 60) begin
                $display("configuration did not finish in time");
                stop_run();
            end
            next_cycle();
        end
        check_value("phase after configuring", com_ready, phase);
        check_value("config data samples", 6, seen.size());
        for (int k = 0; k < 6; k++) check_value("config data slot", words[k / 2], seen[k]);
        check_value("start pulses m0", 2, starts[0]);
        check_value("start pulses m1", 2, starts[1]);
        check_value("address m0", first0, cmd[0].address);
        check_value("address m1", 2000, cmd[1].address);

        foreach (done_delay[m]) done_delay[m] = $urandom_range(10, 3);
        pulse_step();
        cycles = 0;
        while (phase != com_done) begin
            cycles++;
            if (cycles > 40) begin
                $display("masters never led to com_done");
                stop_run();
            end
            next_cycle();
        end
        check_value("done bits at com_done", 3, done_bits);

        new_addr = addr_t'($urandom_range(4095));
        sw = {6'd0, new_addr};
        pulse_next_addr();
        cycles = 0;
        while (cmd[0].address != new_addr) begin
            cycles++;
            if (cycles > 8) begin
                $display("readback address was never loaded");
                stop_run();
            end
            next_cycle();
        end
        check_value("done address m1", new_addr, cmd[1].address);
        next_cycle();                           // readback registers the model word
        for (int m = 0; m < NUM_MASTERS; m++)
            check_value("readback", model_word(m, new_addr), readback[m]);

        next_cycle();
        if (dut.chk.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("bound timing assertions failed");
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* build.f */
logic/bus_setup_pkg.sv
logic/setup_fsm.sv
logic/master_setup_regs.sv
logic/write_data_bank.sv
logic/config_sequencer.sv
logic/bus_setup_top.sv
test/bus_setup_assertions.sv
test/bus_setup_tb.sv
